/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_l1_axi_bridge
RTL_TOP   ?= l1_axi_bridge
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := FAIL: see errors above

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "PASS: all tests" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) \
		common/l1_pkg.sv common/axi_pkg.sv mem_bridge/mem_req_fsm.sv \
		snoop/snoop_fsm.sv source/l1_axi_bridge.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/axi_pkg.sv */
/*
 * AXI4 and ACE encodings
 * Channel field widths, cache attributes, snoop codes
 * and response bit positions used by the bridge
 */
package axi_pkg;

    localparam int AXI_SIZE_BITS  = 3;
    localparam int AXI_CACHE_BITS = 4;
    localparam int AXI_PROT_BITS  = 3;
    localparam int AXI_SNOOP_BITS = 4;
    localparam int AXI_RESP_BITS  = 2;

    // AxCACHE
    localparam logic [AXI_CACHE_BITS-1:0] CACHE_WRBACK_ALLOC = 4'b1111;
    localparam logic [AXI_CACHE_BITS-1:0] CACHE_DEVICE       = 4'b0000;   // Non-bufferable

    // ARSNOOP with ARDOMAIN inner shareable
    localparam logic [AXI_SNOOP_BITS-1:0] ARSNOOP_NO_SNOOP    = 4'd0;
    localparam logic [AXI_SNOOP_BITS-1:0] ARSNOOP_READ_SHARED = 4'd1;
    localparam logic [AXI_SNOOP_BITS-1:0] ARSNOOP_MAKE_UNIQUE = 4'd12;

    // AWSNOOP
    localparam logic [AXI_SNOOP_BITS-1:0] AWSNOOP_NO_SNOOP    = 4'd0;
    localparam logic [AXI_SNOOP_BITS-1:0] AWSNOOP_WRITE_BACK  = 4'd3;
    localparam logic [AXI_SNOOP_BITS-1:0] AWSNOOP_LINE_UNIQUE = 4'd1;

    localparam logic [AXI_SNOOP_BITS-1:0] AC_READ_UNIQUE = 4'd7;

    localparam int RESP_ERR_BIT = 1;        // SLVERR or DECERR

    // CRRESP bits
    localparam int CR_RESP_BITS  = 5;
    localparam int CR_DATA_XFER  = 0;
    localparam int CR_WAS_UNIQUE = 4;

endpackage

/* common/l1_pkg.sv */
/*
 * L1 cache side definitions
 * Widths of the L1 request and snoop channels, request type bits,
 * snoop request types and tag flag positions
 */
package l1_pkg;

    localparam int ADDR_BITS  = 32;
    localparam int LINE_BITS  = 64;         // Shortened cache line
    localparam int LINE_BYTES = LINE_BITS / 8;

    // L1 memory request type
    localparam int REQ_TYPE_BITS   = 3;
    localparam int REQ_TYPE_WRITE  = 0;
    localparam int REQ_TYPE_CACHED = 1;
    localparam int REQ_TYPE_UNIQUE = 2;

    // L1 snoop request type, zero is a flags-only lookup
    localparam int SNOOP_TYPE_BITS      = 2;
    localparam int SNOOP_TYPE_READDATA  = 0;
    localparam int SNOOP_TYPE_READCLEAN = 1;

    // D$ tag flags returned by a snoop lookup
    localparam int FLAG_BITS   = 2;
    localparam int FLAG_VALID  = 0;
    localparam int FLAG_SHARED = 1;

endpackage

/* mem_bridge/mem_req_fsm.sv */
`timescale 1ns/1ps

/*
 * Memory request FSM
 * Issues one L1 request as a single-beat AXI read or write
 * and returns data and faults to the L1 side
 */
module mem_req_fsm
    import l1_pkg::*, axi_pkg::*;
(
    input  logic                      i_clk,
    input  logic                      i_nrst,
    input  logic                      i_req_valid,
    input  logic                      i_req_path,
    input  logic [REQ_TYPE_BITS-1:0]  i_req_type,
    input  logic [AXI_SIZE_BITS-1:0]  i_req_size,
    input  logic [ADDR_BITS-1:0]      i_req_addr,
    input  logic [LINE_BYTES-1:0]     i_req_strb,
    input  logic [LINE_BITS-1:0]      i_req_data,
    input  logic                      i_ar_ready,
    input  logic                      i_r_valid,
    input  logic [LINE_BITS-1:0]      i_r_data,
    input  logic [AXI_RESP_BITS-1:0]  i_r_resp,
    input  logic                      i_r_last,
    input  logic                      i_aw_ready,
    input  logic                      i_w_ready,
    input  logic                      i_b_valid,
    input  logic [AXI_RESP_BITS-1:0]  i_b_resp,
    output logic                      o_req_ready,
    output logic                      o_resp_valid,
    output logic                      o_resp_path,
    output logic [LINE_BITS-1:0]      o_resp_data,
    output logic                      o_resp_load_fault,
    output logic                      o_resp_store_fault,
    output logic                      o_ar_valid,
    output logic [ADDR_BITS-1:0]      o_ar_addr,
    output logic [AXI_SIZE_BITS-1:0]  o_ar_size,
    output logic [AXI_CACHE_BITS-1:0] o_ar_cache,
    output logic [AXI_PROT_BITS-1:0]  o_ar_prot,
    output logic [AXI_SNOOP_BITS-1:0] o_ar_snoop,
    output logic                      o_r_ready,
    output logic                      o_aw_valid,
    output logic [ADDR_BITS-1:0]      o_aw_addr,
    output logic [AXI_SIZE_BITS-1:0]  o_aw_size,
    output logic [AXI_CACHE_BITS-1:0] o_aw_cache,
    output logic [AXI_PROT_BITS-1:0]  o_aw_prot,
    output logic [AXI_SNOOP_BITS-1:0] o_aw_snoop,
    output logic                      o_w_valid,
    output logic [LINE_BITS-1:0]      o_w_data,
    output logic [LINE_BYTES-1:0]     o_w_strb,
    output logic                      o_w_last,
    output logic                      o_b_ready
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_AR, ST_R, ST_AW, ST_W, ST_B
    } state_t;

    state_t state, state_d;

    logic                      path_q;
    logic [ADDR_BITS-1:0]      addr_q;
    logic [AXI_SIZE_BITS-1:0]  size_q;
    logic [AXI_CACHE_BITS-1:0] cache_q;
    logic [AXI_SNOOP_BITS-1:0] snoop_q;
    logic [LINE_BITS-1:0]      wdata_q;
    logic [LINE_BYTES-1:0]     wstrb_q;
    logic [AXI_SNOOP_BITS-1:0] snoop_d;
    logic                      is_write;

    assign is_write = i_req_type[REQ_TYPE_WRITE];

    // Uncached accesses never snoop
    always_comb begin
        if (!i_req_type[REQ_TYPE_CACHED]) begin
            snoop_d = ARSNOOP_NO_SNOOP;
        end else if (is_write) begin
            snoop_d = i_req_type[REQ_TYPE_UNIQUE] ? AWSNOOP_LINE_UNIQUE : AWSNOOP_WRITE_BACK;
        end else begin
            snoop_d = i_req_type[REQ_TYPE_UNIQUE] ? ARSNOOP_MAKE_UNIQUE : ARSNOOP_READ_SHARED;
        end
    end

    always_comb begin
        state_d = state;
        case (state)
            ST_IDLE: if (i_req_valid) state_d = is_write ? ST_AW : ST_AR;
            ST_AR:   if (i_ar_ready) state_d = ST_R;
            ST_R:    if (i_r_valid && i_r_last) state_d = ST_IDLE;
            ST_AW:   if (i_aw_ready) state_d = i_w_ready ? ST_B : ST_W;   // Lone w_ready ignored
            ST_W:    if (i_w_ready) state_d = ST_B;
            ST_B:    if (i_b_valid) state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_d;
        end
    end

    // Request captured while idle
    always_ff @(posedge i_clk) begin
        if (i_req_valid && state == ST_IDLE) begin
            path_q  <= i_req_path;
            addr_q  <= i_req_addr;
            size_q  <= i_req_size;
            cache_q <= i_req_type[REQ_TYPE_CACHED] ? CACHE_WRBACK_ALLOC : CACHE_DEVICE;
            snoop_q <= snoop_d;
            wdata_q <= is_write ? i_req_data : '0;
            wstrb_q <= is_write ? i_req_strb : '0;
        end
    end

    assign o_req_ready = (state == ST_IDLE);

    assign o_ar_valid = (state == ST_AR);
    assign o_ar_addr  = addr_q;
    assign o_ar_size  = size_q;
    assign o_ar_cache = cache_q;
    assign o_ar_prot  = {path_q, {(AXI_PROT_BITS-1){1'b0}}};   // Instruction bit only
    assign o_ar_snoop = snoop_q;
    assign o_r_ready  = (state == ST_R);

    assign o_aw_valid = (state == ST_AW);
    assign o_aw_addr  = addr_q;
    assign o_aw_size  = size_q;
    assign o_aw_cache = cache_q;
    assign o_aw_prot  = {path_q, {(AXI_PROT_BITS-1){1'b0}}};
    assign o_aw_snoop = snoop_q;
    assign o_w_valid  = (state == ST_AW) || (state == ST_W);
    assign o_w_data   = wdata_q;
    assign o_w_strb   = wstrb_q;
    assign o_w_last   = o_w_valid;                              // Single beat
    assign o_b_ready  = (state == ST_B);

    assign o_resp_valid = (state == ST_R && i_r_valid && i_r_last)
                       || (state == ST_B && i_b_valid);
    assign o_resp_path        = path_q;
    assign o_resp_data        = i_r_data;
    assign o_resp_load_fault  = (state == ST_R) && i_r_resp[RESP_ERR_BIT];
    assign o_resp_store_fault = (state == ST_B) && i_b_resp[RESP_ERR_BIT];

    // Slave must end every read with its single beat
    a_r_single_beat: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (state == ST_R && i_r_valid) |-> i_r_last);

    // Nothing in flight on AXI while a new request can be taken
    a_ready_excl: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_req_ready |-> !(o_ar_valid || o_aw_valid || o_w_valid || i_r_valid || i_b_valid));

endmodule

/* sim.f */
common/l1_pkg.sv
common/axi_pkg.sv
mem_bridge/mem_req_fsm.sv
snoop/snoop_fsm.sv
source/l1_axi_bridge.sv
verification/tb_l1_axi_bridge.sv

/* snoop/snoop_fsm.sv */
`timescale 1ns/1ps

/*
 * ACE snoop FSM
 * Looks up the D$ tag flags for each AC snoop, answers on CR
 * and fetches the line for CD when it has to be passed on
 */
module snoop_fsm
    import l1_pkg::*, axi_pkg::*;
(
    input  logic                       i_clk,
    input  logic                       i_nrst,
    input  logic                       i_ac_valid,
    input  logic [ADDR_BITS-1:0]       i_ac_addr,
    input  logic [AXI_SNOOP_BITS-1:0]  i_ac_snoop,
    input  logic                       i_cr_ready,
    input  logic                       i_cd_ready,
    input  logic                       i_snoop_req_ready,
    input  logic                       i_snoop_resp_valid,
    input  logic [FLAG_BITS-1:0]       i_snoop_resp_flags,
    input  logic [LINE_BITS-1:0]       i_snoop_resp_data,
    output logic                       o_ac_ready,
    output logic                       o_cr_valid,
    output logic [CR_RESP_BITS-1:0]    o_cr_resp,
    output logic                       o_cd_valid,
    output logic [LINE_BITS-1:0]       o_cd_data,
    output logic                       o_snoop_req_valid,
    output logic [SNOOP_TYPE_BITS-1:0] o_snoop_req_type,
    output logic [ADDR_BITS-1:0]       o_snoop_req_addr
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_LOOKUP, ST_CR, ST_CR_WAIT, ST_CD, ST_CD_WAIT
    } state_t;

    state_t state, state_d;

    logic                       cache_access;   // Second request reads the line
    logic [SNOOP_TYPE_BITS-1:0] req_type_q;
    logic [ADDR_BITS-1:0]       ac_addr_q;
    logic [AXI_SNOOP_BITS-1:0]  ac_snoop_q;
    logic [CR_RESP_BITS-1:0]    cr_resp_q;
    logic [LINE_BITS-1:0]       line_q;
    logic                       xfer;
    logic [CR_RESP_BITS-1:0]    cr_resp_now;
    logic [SNOOP_TYPE_BITS-1:0] data_type;

    // Line goes out when valid and either exclusive or asked for uniquely
    assign xfer = i_snoop_resp_flags[FLAG_VALID]
               && (!i_snoop_resp_flags[FLAG_SHARED] || ac_snoop_q == AC_READ_UNIQUE);

    always_comb begin
        cr_resp_now = '0;
        data_type   = '0;
        if (xfer) begin
            cr_resp_now[CR_DATA_XFER]  = 1'b1;
            cr_resp_now[CR_WAS_UNIQUE] = 1'b1;
        end
        if (ac_snoop_q == AC_READ_UNIQUE) begin
            data_type[SNOOP_TYPE_READCLEAN] = 1'b1;
        end else begin
            data_type[SNOOP_TYPE_READDATA] = 1'b1;
        end
    end

    always_comb begin
        state_d = state;
        case (state)
            ST_IDLE: begin
                if (i_ac_valid) begin
                    state_d = i_snoop_req_ready ? ST_CR : ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (i_snoop_req_ready) begin
                    state_d = cache_access ? ST_CD : ST_CR;
                end
            end
            ST_CR: begin
                if (i_snoop_resp_valid) begin
                    if (!i_cr_ready) begin
                        state_d = ST_CR_WAIT;
                    end else begin
                        state_d = xfer ? ST_LOOKUP : ST_IDLE;
                    end
                end
            end
            ST_CR_WAIT: begin
                if (i_cr_ready) begin
                    state_d = cache_access ? ST_LOOKUP : ST_IDLE;
                end
            end
            ST_CD: begin
                if (i_snoop_resp_valid) begin
                    state_d = i_cd_ready ? ST_IDLE : ST_CD_WAIT;
                end
            end
            ST_CD_WAIT: if (i_cd_ready) state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state        <= ST_IDLE;
            cache_access <= 1'b0;
            req_type_q   <= '0;
        end else begin
            state <= state_d;
            if (state == ST_IDLE && i_ac_valid) begin
                cache_access <= 1'b0;
                req_type_q   <= '0;                     // First pass reads flags only
            end else if (state == ST_CR && i_snoop_resp_valid && xfer) begin
                cache_access <= 1'b1;
                req_type_q   <= data_type;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == ST_IDLE && i_ac_valid) begin
            ac_addr_q  <= i_ac_addr;
            ac_snoop_q <= i_ac_snoop;
        end
        if (state == ST_CR && i_snoop_resp_valid) begin
            cr_resp_q <= cr_resp_now;
        end
        if (state == ST_CD && i_snoop_resp_valid) begin
            line_q <= i_snoop_resp_data;
        end
    end

    assign o_ac_ready = (state == ST_IDLE);

    // Lookup leaves in the AC cycle itself and retries from the held copy
    assign o_snoop_req_valid = (state == ST_IDLE && i_ac_valid) || (state == ST_LOOKUP);
    assign o_snoop_req_type  = (state == ST_LOOKUP) ? req_type_q : '0;
    assign o_snoop_req_addr  = (state == ST_IDLE) ? i_ac_addr : ac_addr_q;

    assign o_cr_valid = (state == ST_CR && i_snoop_resp_valid) || (state == ST_CR_WAIT);
    assign o_cr_resp  = (state == ST_CR_WAIT) ? cr_resp_q : cr_resp_now;
    assign o_cd_valid = (state == ST_CD && i_snoop_resp_valid) || (state == ST_CD_WAIT);
    assign o_cd_data  = (state == ST_CD_WAIT) ? line_q : i_snoop_resp_data;

    // L1 answers only an outstanding request
    a_no_stray_resp: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_ac_ready |-> !i_snoop_resp_valid);

    // Line held across CD back-pressure
    a_cd_stable: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (o_cd_valid && !i_cd_ready) |=> (o_cd_valid && $stable(o_cd_data)));

endmodule

/* source/l1_axi_bridge.sv */
`timescale 1ns/1ps

/*
 * L1 to AXI4/ACE bridge
 * Joins the memory request path and the snoop path of the L1 caches
 * to a coherent interconnect port
 */
module l1_axi_bridge
    import l1_pkg::*, axi_pkg::*;
(
    input  logic                       i_clk,
    input  logic                       i_nrst,
    // L1 memory request and response
    input  logic                       i_req_valid,
    input  logic                       i_req_path,
    input  logic [REQ_TYPE_BITS-1:0]   i_req_type,
    input  logic [AXI_SIZE_BITS-1:0]   i_req_size,
    input  logic [ADDR_BITS-1:0]       i_req_addr,
    input  logic [LINE_BYTES-1:0]      i_req_strb,
    input  logic [LINE_BITS-1:0]       i_req_data,
    output logic                       o_req_ready,
    output logic                       o_resp_valid,
    output logic                       o_resp_path,
    output logic [LINE_BITS-1:0]       o_resp_data,
    output logic                       o_resp_load_fault,
    output logic                       o_resp_store_fault,
    // L1 snoop request and response
    output logic                       o_snoop_req_valid,
    output logic [SNOOP_TYPE_BITS-1:0] o_snoop_req_type,
    output logic [ADDR_BITS-1:0]       o_snoop_req_addr,
    input  logic                       i_snoop_req_ready,
    input  logic                       i_snoop_resp_valid,
    input  logic [FLAG_BITS-1:0]       i_snoop_resp_flags,
    input  logic [LINE_BITS-1:0]       i_snoop_resp_data,
    // AXI read
    output logic                       o_ar_valid,
    input  logic                       i_ar_ready,
    output logic [ADDR_BITS-1:0]       o_ar_addr,
    output logic [AXI_SIZE_BITS-1:0]   o_ar_size,
    output logic [AXI_CACHE_BITS-1:0]  o_ar_cache,
    output logic [AXI_PROT_BITS-1:0]   o_ar_prot,
    output logic [AXI_SNOOP_BITS-1:0]  o_ar_snoop,
    input  logic                       i_r_valid,
    output logic                       o_r_ready,
    input  logic [LINE_BITS-1:0]       i_r_data,
    input  logic [AXI_RESP_BITS-1:0]   i_r_resp,
    input  logic                       i_r_last,
    // AXI write
    output logic                       o_aw_valid,
    input  logic                       i_aw_ready,
    output logic [ADDR_BITS-1:0]       o_aw_addr,
    output logic [AXI_SIZE_BITS-1:0]   o_aw_size,
    output logic [AXI_CACHE_BITS-1:0]  o_aw_cache,
    output logic [AXI_PROT_BITS-1:0]   o_aw_prot,
    output logic [AXI_SNOOP_BITS-1:0]  o_aw_snoop,
    output logic                       o_w_valid,
    input  logic                       i_w_ready,
    output logic [LINE_BITS-1:0]       o_w_data,
    output logic [LINE_BYTES-1:0]      o_w_strb,
    output logic                       o_w_last,
    input  logic                       i_b_valid,
    output logic                       o_b_ready,
    input  logic [AXI_RESP_BITS-1:0]   i_b_resp,
    // ACE snoop channels
    input  logic                       i_ac_valid,
    output logic                       o_ac_ready,
    input  logic [ADDR_BITS-1:0]       i_ac_addr,
    input  logic [AXI_SNOOP_BITS-1:0]  i_ac_snoop,
    output logic                       o_cr_valid,
    input  logic                       i_cr_ready,
    output logic [CR_RESP_BITS-1:0]    o_cr_resp,
    output logic                       o_cd_valid,
    input  logic                       i_cd_ready,
    output logic [LINE_BITS-1:0]       o_cd_data
);

    // Port names match one to one, the two halves share only clock and reset
    mem_req_fsm u_mem_req_fsm (.*);

    snoop_fsm u_snoop_fsm (.*);

endmodule

/* verification/tb_l1_axi_bridge.sv */
`timescale 1ns/1ps

/*
 * Testbench for the L1 to AXI4/ACE bridge
 * Applies a table of reads, writes and snoops with AXI slave and L1 models
 */
module tb_l1_axi_bridge;
    import l1_pkg::*, axi_pkg::*;

    localparam int OP_READ = 0;
    localparam int OP_WRITE = 1;
    localparam int OP_SNOOP = 2;
    localparam int MAX_WAIT = 50;
    // Selectors for wait_for
    localparam int P_REQ_READY = 0;
    localparam int P_AR = 1;
    localparam int P_AW = 2;
    localparam int P_W = 3;
    localparam int P_B_READY = 4;
    localparam int P_AC_READY = 5;
    localparam int P_SNP_REQ = 6;

    typedef struct {
        int          op;
        logic [2:0]  rtype;
        logic        path;
        logic [31:0] addr;
        logic [63:0] data;
        logic [7:0]  strb;
        logic [1:0]  resp;
        bit          delay;
        bit          late_w;
        logic [3:0]  snoop;
        logic [1:0]  flags;
    } row_t;

    logic i_clk, i_nrst;
    logic i_req_valid, i_req_path, o_req_ready, o_resp_valid, o_resp_path;
    logic [2:0] i_req_type, i_req_size;
    logic [31:0] i_req_addr, o_snoop_req_addr, o_ar_addr, o_aw_addr, i_ac_addr;
    logic [7:0] i_req_strb, o_w_strb;
    logic [63:0] i_req_data, o_resp_data, i_snoop_resp_data, i_r_data, o_w_data, o_cd_data;
    logic o_resp_load_fault, o_resp_store_fault;
    logic o_snoop_req_valid, i_snoop_req_ready, i_snoop_resp_valid;
    logic [1:0] o_snoop_req_type, i_snoop_resp_flags, i_r_resp, i_b_resp;
    logic o_ar_valid, i_ar_ready, i_r_valid, o_r_ready, i_r_last;
    logic [2:0] o_ar_size, o_ar_prot, o_aw_size, o_aw_prot;
    logic [3:0] o_ar_cache, o_ar_snoop, o_aw_cache, o_aw_snoop, i_ac_snoop;
    logic o_aw_valid, i_aw_ready, o_w_valid, i_w_ready, o_w_last, i_b_valid, o_b_ready;
    logic i_ac_valid, o_ac_ready, o_cr_valid, i_cr_ready, o_cd_valid, i_cd_ready;
    logic [4:0] o_cr_resp;

    row_t rows[$];
    int   errors = 0;
    int   checks = 0;

    l1_axi_bridge u_l1_axi_bridge (.*);

    always #10 i_clk = ~i_clk;

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR @%0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    // Next drive point just after the rising edge
    task automatic step();
        @(posedge i_clk);
        #1;
    endtask

    function automatic logic probe(input int sel);
        case (sel)
            P_REQ_READY: return o_req_ready;
            P_AR:        return o_ar_valid;
            P_AW:        return o_aw_valid;
            P_W:         return o_w_valid;
            P_B_READY:   return o_b_ready;
            P_AC_READY:  return o_ac_ready;
            default:     return o_snoop_req_valid;
        endcase
    endfunction

    // Returns at the falling edge with the signal high
    task automatic wait_for(input int sel, input string name);
        int n;
        for (n = 0; n < MAX_WAIT; n++) begin
            @(negedge i_clk);
            if (probe(sel)) return;
            step();
        end
        $display("Timeout: %s never responded within %0d cycles", name, MAX_WAIT);
        $display("FAIL: see errors above");
        $finish;
    endtask

    function automatic int pick_delay(input bit en);
        return en ? $urandom_range(3, 1) : 0;
    endfunction

    // Expected attributes from the request type rules
    function automatic logic [3:0] exp_cache(input logic [2:0] t);
        return t[REQ_TYPE_CACHED] ? 4'b1111 : 4'b0000;
    endfunction

    function automatic logic [3:0] exp_snoop(input logic [2:0] t);
        if (!t[REQ_TYPE_CACHED]) return 4'd0;
        if (t[REQ_TYPE_WRITE]) return t[REQ_TYPE_UNIQUE] ? 4'd1 : 4'd3;
        return t[REQ_TYPE_UNIQUE] ? 4'd12 : 4'd1;
    endfunction

    function automatic bit exp_xfer(input logic [1:0] flags, input logic [3:0] snoop);
        return flags[FLAG_VALID] && (!flags[FLAG_SHARED] || snoop == 4'd7);
    endfunction

    task automatic add_row(input int op, input logic [2:0] rtype, input logic path,
                           input logic [31:0] addr, input logic [63:0] data,
                           input logic [7:0] strb, input logic [1:0] resp, input bit delay,
                           input bit late_w, input logic [3:0] snoop, input logic [1:0] flags);
        row_t r;
        r = '{op, rtype, path, addr, data, strb, resp, delay, late_w, snoop, flags};
        rows.push_back(r);
    endtask

    task automatic send_req(input row_t r);
        i_req_valid = 1'b1;
        i_req_type  = r.rtype;
        i_req_path  = r.path;
        i_req_addr  = r.addr;
        i_req_data  = r.data;
        i_req_strb  = r.strb;
        wait_for(P_REQ_READY, "o_req_ready");
        step();
        i_req_valid = 1'b0;
        i_req_type  = ~r.rtype;     // Payload only counts in the accept cycle
        i_req_path  = ~r.path;
        i_req_addr  = ~r.addr;
        i_req_data  = ~r.data;
        i_req_strb  = ~r.strb;
    endtask

    task automatic run_read(input row_t r);
        send_req(r);
        wait_for(P_AR, "AR valid");
        step();
        repeat (pick_delay(r.delay)) step();
        i_ar_ready = 1'b1;
        @(negedge i_clk);
        check(64'(o_ar_addr), 64'(r.addr), "ar_addr");
        check(64'(o_ar_size), 64'(3'd3), "ar_size");
        check(64'(o_ar_cache), 64'(exp_cache(r.rtype)), "ar_cache");
        check(64'(o_ar_snoop), 64'(exp_snoop(r.rtype)), "ar_snoop");
        check(64'(o_ar_prot), 64'({r.path, 2'b00}), "ar_prot");
        step();
        i_ar_ready = 1'b0;
        repeat (pick_delay(r.delay)) step();
        i_r_valid = 1'b1;
        i_r_last  = 1'b1;
        i_r_data  = r.data;
        i_r_resp  = r.resp;
        @(negedge i_clk);
        check(64'(o_r_ready), 64'(1), "r_ready");
        check(64'(o_resp_valid), 64'(1), "read resp_valid");
        check(o_resp_data, r.data, "resp_data");
        check(64'(o_resp_path), 64'(r.path), "resp_path");
        check(64'(o_resp_load_fault), 64'(r.resp[RESP_ERR_BIT]), "load_fault");
        check(64'(o_resp_store_fault), 64'(0), "store_fault on read");
        step();
        i_r_valid = 1'b0;
        i_r_last  = 1'b0;
    endtask

    task automatic run_write(input row_t r);
        send_req(r);
        wait_for(P_AW, "AW valid");
        step();
        repeat (pick_delay(r.delay)) step();
        i_aw_ready = 1'b1;
        i_w_ready  = !r.late_w;
        @(negedge i_clk);
        check(64'(o_aw_addr), 64'(r.addr), "aw_addr");
        check(64'(o_aw_size), 64'(3'd3), "aw_size");
        check(64'(o_aw_cache), 64'(exp_cache(r.rtype)), "aw_cache");
        check(64'(o_aw_snoop), 64'(exp_snoop(r.rtype)), "aw_snoop");
        check(64'(o_aw_prot), 64'({r.path, 2'b00}), "aw_prot");
        check(64'(o_w_valid), 64'(1), "w_valid with aw");
        check(o_w_data, r.data, "w_data");
        check(64'(o_w_strb), 64'(r.strb), "w_strb");
        check(64'(o_w_last), 64'(1), "w_last");
        step();
        i_aw_ready = 1'b0;
        i_w_ready  = 1'b0;
        if (r.late_w) begin
            wait_for(P_W, "W valid");
            check(64'(o_aw_valid), 64'(0), "aw_valid after accept");
            step();
            repeat (pick_delay(r.delay)) step();
            i_w_ready = 1'b1;
            @(negedge i_clk);
            check(o_w_data, r.data, "late w_data");
            step();
            i_w_ready = 1'b0;
        end
        wait_for(P_B_READY, "b_ready");
        step();
        repeat (pick_delay(r.delay)) step();
        i_b_valid = 1'b1;
        i_b_resp  = r.resp;
        @(negedge i_clk);
        check(64'(o_resp_valid), 64'(1), "write resp_valid");
        check(64'(o_resp_store_fault), 64'(r.resp[RESP_ERR_BIT]), "store_fault");
        check(64'(o_resp_load_fault), 64'(0), "load_fault on write");
        step();
        i_b_valid = 1'b0;
    endtask

    task automatic run_snoop(input row_t r);
        int  d;
        bit  xfer;
        xfer = exp_xfer(r.flags, r.snoop);
        d = pick_delay(r.delay);
        i_ac_valid        = 1'b1;
        i_ac_addr         = r.addr;
        i_ac_snoop        = r.snoop;
        i_snoop_req_ready = (d == 0);
        wait_for(P_AC_READY, "ac_ready");
        check(64'(o_snoop_req_valid), 64'(1), "lookup valid");
        check(64'(o_snoop_req_type), 64'(0), "lookup type");
        check(64'(o_snoop_req_addr), 64'(r.addr), "lookup addr");
        step();
        i_ac_valid = 1'b0;
        i_ac_addr  = ~r.addr;       // Address must come from the held copy now
        if (d > 0) begin
            repeat (d - 1) step();
            i_snoop_req_ready = 1'b1;
            @(negedge i_clk);
            check(64'(o_snoop_req_type), 64'(0), "retried lookup type");
            check(64'(o_snoop_req_addr), 64'(r.addr), "retried lookup addr");
            step();
        end
        i_snoop_req_ready = 1'b0;
        repeat (pick_delay(r.delay)) step();
        d = pick_delay(r.delay);
        i_snoop_resp_valid = 1'b1;
        i_snoop_resp_flags = r.flags;
        i_cr_ready         = (d == 0);
        @(negedge i_clk);
        check(64'(o_cr_valid), 64'(1), "cr_valid");
        check(64'(o_cr_resp), xfer ? 64'h11 : 64'h0, "cr_resp");
        step();
        i_snoop_resp_valid = 1'b0;
        i_snoop_resp_flags = ~r.flags;  // Response must come from the held copy now
        if (d > 0) begin
            repeat (d - 1) step();
            i_cr_ready = 1'b1;
            @(negedge i_clk);
            check(64'(o_cr_resp), xfer ? 64'h11 : 64'h0, "held cr_resp");
            step();
        end
        i_cr_ready = 1'b0;
        if (!xfer) begin
            repeat (5) begin
                @(negedge i_clk);
                check(64'(o_snoop_req_valid), 64'(0), "no second request");
                check(64'(o_cd_valid), 64'(0), "no cd_valid");
                step();
            end
            return;
        end
        wait_for(P_SNP_REQ, "data request");
        check(64'(o_snoop_req_type), (r.snoop == 4'd7) ? 64'd2 : 64'd1, "data request type");
        check(64'(o_snoop_req_addr), 64'(r.addr), "data request addr");
        step();
        i_snoop_req_ready = 1'b1;
        @(negedge i_clk);
        step();
        i_snoop_req_ready = 1'b0;
        repeat (pick_delay(r.delay)) step();
        d = pick_delay(r.delay);
        i_snoop_resp_valid = 1'b1;
        i_snoop_resp_data  = r.data;
        i_cd_ready         = (d == 0);
        @(negedge i_clk);
        check(64'(o_cd_valid), 64'(1), "cd_valid");
        check(o_cd_data, r.data, "cd_data");
        step();
        i_snoop_resp_valid = 1'b0;
        i_snoop_resp_data  = ~r.data;   // Line must come from the held copy now
        if (d > 0) begin
            repeat (d - 1) step();
            i_cd_ready = 1'b1;
            @(negedge i_clk);
            check(64'(o_cd_valid), 64'(1), "held cd_valid");
            check(o_cd_data, r.data, "held cd_data");
            step();
        end
        i_cd_ready = 1'b0;
    endtask

    initial begin
        void'($urandom(6));
        i_clk              = 1'b0;
        i_nrst             = 1'b0;
        i_req_valid        = 1'b0;
        i_req_path         = 1'b0;
        i_req_type         = '0;
        i_req_size         = 3'd3;
        i_req_addr         = '0;
        i_req_strb         = '0;
        i_req_data         = '0;
        i_snoop_req_ready  = 1'b0;
        i_snoop_resp_valid = 1'b0;
        i_snoop_resp_flags = '0;
        i_snoop_resp_data  = '0;
        i_ar_ready         = 1'b0;
        i_r_valid          = 1'b0;
        i_r_data           = '0;
        i_r_resp           = '0;
        i_r_last           = 1'b0;
        i_aw_ready         = 1'b0;
        i_w_ready          = 1'b0;
        i_b_valid          = 1'b0;
        i_b_resp           = '0;
        i_ac_valid         = 1'b0;
        i_ac_addr          = '0;
        i_ac_snoop         = '0;
        i_cr_ready         = 1'b0;
        i_cd_ready         = 1'b0;

        //      op        type  path addr          data                   strb   resp delay late snoop flags
        add_row(OP_READ,  3'd0, 0, 32'h0000_1000, 64'h0123_4567_89ab_cdef, 8'h00, 2'd0, 0, 0, 4'd0, 2'd0);
        add_row(OP_READ,  3'd2, 1, 32'h0000_2040, 64'hdead_beef_0bad_f00d, 8'h00, 2'd0, 1, 0, 4'd0, 2'd0);
        add_row(OP_READ,  3'd6, 0, 32'h8000_0080, 64'h1111_2222_3333_4444, 8'h00, 2'd0, 1, 0, 4'd0, 2'd0);
        add_row(OP_READ,  3'd2, 0, 32'h0000_3000, 64'h5555_6666_7777_8888, 8'h00, 2'd2, 0, 0, 4'd0, 2'd0);
        add_row(OP_WRITE, 3'd1, 0, 32'h1000_0008, 64'h0f0f_0f0f_f0f0_f0f0, 8'h0f, 2'd0, 0, 0, 4'd0, 2'd0);
        add_row(OP_WRITE, 3'd3, 1, 32'h1000_0040, 64'hcafe_babe_1234_5678, 8'hff, 2'd0, 1, 1, 4'd0, 2'd0);
        add_row(OP_WRITE, 3'd7, 0, 32'h1000_0080, 64'h9999_aaaa_bbbb_cccc, 8'hf0, 2'd0, 1, 0, 4'd0, 2'd0);
        add_row(OP_WRITE, 3'd3, 0, 32'h1000_00c0, 64'h0000_ffff_0000_ffff, 8'h3c, 2'd3, 0, 1, 4'd0, 2'd0);
        add_row(OP_SNOOP, 3'd0, 0, 32'h0000_4000, 64'hfeed_face_0000_0001, 8'h00, 2'd0, 0, 0, 4'd1, 2'd1);
        add_row(OP_SNOOP, 3'd0, 0, 32'h0000_4040, 64'hfeed_face_0000_0002, 8'h00, 2'd0, 1, 0, 4'd7, 2'd3);
        add_row(OP_SNOOP, 3'd0, 0, 32'h0000_4080, 64'hfeed_face_0000_0003, 8'h00, 2'd0, 1, 0, 4'd1, 2'd3);
        add_row(OP_SNOOP, 3'd0, 0, 32'h0000_40c0, 64'hfeed_face_0000_0004, 8'h00, 2'd0, 0, 0, 4'd7, 2'd0);
        add_row(OP_SNOOP, 3'd0, 0, 32'h0000_4100, 64'hfeed_face_0000_0005, 8'h00, 2'd0, 1, 0, 4'd1, 2'd1);

        repeat (2) @(posedge i_clk);
        #1 i_nrst = 1;
        @(negedge i_clk);
        check(64'({o_ar_valid, o_aw_valid, o_w_valid, o_resp_valid}), 64'(0),
              "mem valids after reset");
        check(64'({o_cr_valid, o_cd_valid, o_snoop_req_valid}), 64'(0),
              "snoop valids after reset");
        check(64'(o_req_ready), 64'(1), "req_ready after reset");
        check(64'(o_ac_ready), 64'(1), "ac_ready after reset");
        step();

        foreach (rows[i]) begin
            case (rows[i].op)
                OP_READ:  run_read(rows[i]);
                OP_WRITE: run_write(rows[i]);
                default:  run_snoop(rows[i]);
            endcase
            if (rows[i].op == OP_SNOOP) wait_for(P_AC_READY, "ac_ready at snoop end");
            else wait_for(P_REQ_READY, "o_req_ready at request end");
            step();
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
